// File: axis_beat_pkg.sv
// 64-bit stream beat and byte lane helpers

package axis_beat_pkg;

    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [KEEP_W-1:0] keep_t;
    typedef logic [3:0]        byte_cnt_t;

    // travels with a valid/ready pair
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } axis_beat_t;

    // number of contiguous enabled bytes from lane 0
    function automatic byte_cnt_t keep_to_count(input keep_t keep);
        byte_cnt_t cnt;
        logic      run;
        cnt = '0;
        run = 1'b1;
        for (int i = 0; i < KEEP_W; i++) begin
            run = run & keep[i];
            cnt = cnt + byte_cnt_t'(run);
        end
        return cnt;
    endfunction

    // mask with the low cnt lanes enabled
    function automatic keep_t count_to_keep(input byte_cnt_t cnt);
        keep_t keep;
        for (int i = 0; i < KEEP_W; i++) begin
            keep[i] = (i < cnt);
        end
        return keep;
    endfunction

endpackage

// File: axis_skid_buffer.sv
// two-entry output slice for the payload stream

`timescale 1ns/1ps

module axis_skid_buffer
    import axis_beat_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready_early,

    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    logic       in_ready_reg;
    logic       out_valid_next;
    axis_beat_t temp_beat;
    logic       temp_valid;
    logic       temp_valid_next;

    logic       in_to_out;
    logic       in_to_temp;
    logic       temp_to_out;

    // next cycle can accept unless temp would fill up
    assign in_ready_early = out_ready || (!temp_valid && (!out_valid || !in_valid));

    always_comb begin
        out_valid_next  = out_valid;
        temp_valid_next = temp_valid;
        in_to_out       = 1'b0;
        in_to_temp      = 1'b0;
        temp_to_out     = 1'b0;

        if (in_ready_reg) begin
            if (out_ready || !out_valid) begin
                out_valid_next = in_valid;
                in_to_out      = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next = in_valid;
                in_to_temp      = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next  = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready_reg <= 1'b0;
            out_valid    <= 1'b0;
            temp_valid   <= 1'b0;
        end else begin
            in_ready_reg <= in_ready_early;
            out_valid    <= out_valid_next;
            temp_valid   <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_beat <= in_beat;
        end else if (temp_to_out) begin
            out_beat <= temp_beat;
        end
        if (in_to_temp) begin
            temp_beat <= in_beat;
        end
    end

    // a stalled beat is held until taken
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat changed while stalled");

endmodule

// File: flist.f
+incdir+.
net_hdr_pkg.sv
axis_beat_pkg.sv
udp_rx_ctrl.sv
axis_skid_buffer.sv
udp_ip_rx.sv
tb_udp_ip_rx.sv

// File: net_hdr_pkg.sv
// Ethernet, IPv4 and UDP header formats

package net_hdr_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len16_t;

    // bytes taken by the UDP header at the start of the IP payload
    localparam int UDP_HDR_BYTES = 8;

    // ethernet and IPv4 fields, options not carried
    typedef struct packed {
        mac_addr_t   eth_dest_mac;
        mac_addr_t   eth_src_mac;
        logic [15:0] eth_type;
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        len16_t      length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        len16_t      header_checksum;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
    } ip_hdr_t;

    // udp fields are held in host order
    typedef struct packed {
        ip_hdr_t ip;
        port_t   source_port;
        port_t   dest_port;
        len16_t  length;
        len16_t  checksum;
    } udp_hdr_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_udp_ip_rx -f flist.f --Mdir obj_dir

./obj_dir/Vtb_udp_ip_rx | tee sim.log

if grep -qx "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tb_udp_tasks.svh
// UDP receiver test tasks

`ifndef TB_UDP_TASKS_SVH
`define TB_UDP_TASKS_SVH

task automatic check_equal(input logic [511:0] actual, input logic [511:0] expected,
                           input string what);
    if (actual !== expected) begin
        errors++;
        $display("FAILED at %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
endtask

// builds the IP payload bytes and queues the expected header and beats
task automatic prepare_frame(input int udp_len, input int n_bytes, output ip_hdr_t hdr);
    udp_hdr_t    exp_hdr;
    axis_beat_t  beat;
    logic [63:0] fields;
    int          n_out;
    for (int i = 0; i < $bits(ip_hdr_t) / 8; i++) begin
        hdr[i*8 +: 8] = 8'($random(seed));
    end
    exp_hdr.ip          = hdr;
    exp_hdr.source_port = 16'($random(seed));
    exp_hdr.dest_port   = 16'($random(seed));
    exp_hdr.length      = 16'(udp_len);
    exp_hdr.checksum    = 16'($random(seed));
    fields = {exp_hdr.source_port, exp_hdr.dest_port, exp_hdr.length, exp_hdr.checksum};
    // network order, most significant byte first
    frame_bytes.delete();
    for (int i = 7; i >= 0; i--) begin
        frame_bytes.push_back(fields[i*8 +: 8]);
    end
    for (int i = 0; i < n_bytes; i++) begin
        frame_bytes.push_back(8'($random(seed)));
    end
    if (n_bytes > 0) begin
        exp_hdrs.push_back(exp_hdr);
    end
    // payload cut at the udp length
    n_out = (n_bytes < udp_len - 8) ? n_bytes : udp_len - 8;
    for (int b = 0; b * 8 < n_out; b++) begin
        beat = '0;
        for (int k = 0; k < 8 && b * 8 + k < n_out; k++) begin
            beat.data[k*8 +: 8] = frame_bytes[8 + b * 8 + k];
            beat.keep[k]        = 1'b1;
        end
        beat.last = (b * 8 + 8 >= n_out);
        beat.user = beat.last && (n_bytes < udp_len - 8);
        exp_beats.push_back(beat);
    end
endtask

task automatic send_frame(input ip_hdr_t hdr);
    axis_beat_t beat;
    int         i;
    ip_hdr       = hdr;
    ip_hdr_valid = 1'b1;
    do @(posedge clk); while (!ip_hdr_ready);
    #1;
    ip_hdr_valid = 1'b0;
    // frame in progress from the header transfer on
    check_equal(busy, 1'b1, "busy after the header transfer");
    i = 0;
    while (i < frame_bytes.size()) begin
        beat = '0;
        for (int k = 0; k < 8 && i < frame_bytes.size(); k++) begin
            beat.data[k*8 +: 8] = frame_bytes[i];
            beat.keep[k]        = 1'b1;
            i++;
        end
        beat.last        = (i == frame_bytes.size());
        ip_payload       = beat;
        ip_payload_valid = 1'b1;
        do @(posedge clk); while (!ip_payload_ready);
        #1;
    end
    ip_payload_valid = 1'b0;
endtask

// outputs quiet for a few cycles means the frame has drained
task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < 3) begin
        @(posedge clk);
        if (!udp_payload_valid && !udp_hdr_valid) begin
            quiet++;
        end else begin
            quiet = 0;
        end
    end
    #1;
endtask

task automatic compare_results(input string name, input int exp_hdr_err, input int exp_pay_err);
    logic [63:0] lanes;
    check_equal(out_hdrs.size(), exp_hdrs.size(), {name, ": header count"});
    check_equal(out_beats.size(), exp_beats.size(), {name, ": beat count"});
    for (int i = 0; i < out_hdrs.size() && i < exp_hdrs.size(); i++) begin
        check_equal(out_hdrs[i], exp_hdrs[i], $sformatf("%s: header %0d", name, i));
    end
    for (int i = 0; i < out_beats.size() && i < exp_beats.size(); i++) begin
        // disabled lanes carry don't-care data
        for (int k = 0; k < 8; k++) begin
            lanes[k*8 +: 8] = {8{exp_beats[i].keep[k]}};
        end
        check_equal(out_beats[i].data & lanes, exp_beats[i].data,
                    $sformatf("%s: beat %0d data", name, i));
        check_equal({out_beats[i].keep, out_beats[i].last, out_beats[i].user},
                    {exp_beats[i].keep, exp_beats[i].last, exp_beats[i].user},
                    $sformatf("%s: beat %0d keep, last and user", name, i));
    end
    check_equal(hdr_err_pulses, exp_hdr_err, {name, ": header error pulses"});
    check_equal(pay_err_pulses, exp_pay_err, {name, ": payload error pulses"});
endtask

task automatic start_test();
    tests_run++;
    out_beats.delete();
    exp_beats.delete();
    out_hdrs.delete();
    exp_hdrs.delete();
    hdr_err_pulses = 0;
    pay_err_pulses = 0;
endtask

task automatic single_frame_test(input string name, input int udp_len, input int n_bytes,
                                 input int exp_hdr_err, input int exp_pay_err);
    ip_hdr_t hdr;
    start_test();
    prepare_frame(udp_len, n_bytes, hdr);
    send_frame(hdr);
    wait_idle();
    compare_results(name, exp_hdr_err, exp_pay_err);
endtask

task automatic test_exact_length();
    single_frame_test("exact length", 28, 20, 0, 0);
endtask

// 21 bytes end mid-beat, two more beats of padding follow
task automatic test_padded();
    single_frame_test("padded", 29, 40, 0, 0);
endtask

task automatic test_payload_early_end();
    single_frame_test("payload early end", 48, 19, 0, 1);
endtask

// only the 8-byte udp header beat, carrying tlast
task automatic test_header_early_end();
    single_frame_test("header early end", 16, 0, 1, 0);
endtask

task automatic test_backpressure();
    ip_hdr_t hdr;
    start_test();
    random_ready = 1'b1;
    prepare_frame(38, 30, hdr);
    send_frame(hdr);
    prepare_frame(25, 27, hdr);
    send_frame(hdr);
    prepare_frame(72, 64, hdr);
    send_frame(hdr);
    wait_idle();
    random_ready = 1'b0;
    compare_results("back-pressure", 0, 0);
    check_equal(busy, 1'b0, "busy after the back-pressure run");
    check_equal(ip_hdr_ready, 1'b1, "ip_hdr_ready once idle");
endtask

`endif

// File: tb_udp_ip_rx.sv
// UDP receiver testbench

`timescale 1ns/1ps

module tb_udp_ip_rx
    import net_hdr_pkg::*, axis_beat_pkg::*;
();

    localparam int NUM_TESTS = 5;

    logic       clk;
    logic       rst;
    logic       ip_hdr_valid;
    logic       ip_hdr_ready;
    ip_hdr_t    ip_hdr;
    logic       ip_payload_valid;
    logic       ip_payload_ready;
    axis_beat_t ip_payload;
    logic       udp_hdr_valid;
    logic       udp_hdr_ready;
    udp_hdr_t   udp_hdr;
    logic       udp_payload_valid;
    logic       udp_payload_ready;
    axis_beat_t udp_payload;
    logic       busy;
    logic       error_header_early_termination;
    logic       error_payload_early_termination;

    integer     seed;
    int         errors;
    int         tests_run;
    logic       random_ready;
    int         hdr_err_pulses;
    int         pay_err_pulses;
    logic [7:0] frame_bytes[$];
    axis_beat_t out_beats[$];
    axis_beat_t exp_beats[$];
    udp_hdr_t   out_hdrs[$];
    udp_hdr_t   exp_hdrs[$];

    udp_ip_rx dut0 (.*);

    `include "tb_udp_tasks.svh"

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // output back-pressure, random only in the stress test
    always @(posedge clk) begin
        #1;
        udp_payload_ready = !random_ready || (($random(seed) & 1) != 0);
        udp_hdr_ready     = !random_ready || (($random(seed) & 1) != 0);
    end

    // output monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (udp_payload_valid && udp_payload_ready) begin
                out_beats.push_back(udp_payload);
            end
            if (udp_hdr_valid && udp_hdr_ready) begin
                out_hdrs.push_back(udp_hdr);
            end
            if (error_header_early_termination) begin
                hdr_err_pulses++;
            end
            if (error_payload_early_termination) begin
                pay_err_pulses++;
            end
        end
    end

    initial begin
        seed              = 36432;
        errors            = 0;
        tests_run         = 0;
        random_ready      = 1'b0;
        rst               = 1'b1;
        ip_hdr_valid      = 1'b0;
        ip_hdr            = '0;
        ip_payload_valid  = 1'b0;
        ip_payload        = '0;
        udp_hdr_ready     = 1'b1;
        udp_payload_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_equal(ip_hdr_ready, 1'b0, "ip_hdr_ready in the first cycle after reset");
        @(posedge clk);
        #1;
        check_equal(ip_hdr_ready, 1'b1, "ip_hdr_ready in the second cycle after reset");
        test_exact_length();
        test_padded();
        test_payload_early_end();
        test_header_early_end();
        test_backpressure();
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_TESTS * 2000);
        $display("timeout: the tests did not finish within %0d ns", NUM_TESTS * 2000);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: udp_ip_rx.sv
// UDP frame receiver, 64-bit datapath

`timescale 1ns/1ps

module udp_ip_rx
    import net_hdr_pkg::*, axis_beat_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       ip_hdr_valid,
    output logic       ip_hdr_ready,
    input  ip_hdr_t    ip_hdr,

    input  logic       ip_payload_valid,
    output logic       ip_payload_ready,
    input  axis_beat_t ip_payload,

    output logic       udp_hdr_valid,
    input  logic       udp_hdr_ready,
    output udp_hdr_t   udp_hdr,

    output logic       udp_payload_valid,
    input  logic       udp_payload_ready,
    output axis_beat_t udp_payload,

    output logic       busy,
    output logic       error_header_early_termination,
    output logic       error_payload_early_termination
);

    // controller to output slice
    axis_beat_t int_beat;
    logic       int_valid;
    logic       int_ready_early;

    udp_rx_ctrl ctrl0 (
        .clk                             (clk),
        .rst                             (rst),
        .ip_hdr_valid                    (ip_hdr_valid),
        .ip_hdr_ready                    (ip_hdr_ready),
        .ip_hdr                          (ip_hdr),
        .ip_payload_valid                (ip_payload_valid),
        .ip_payload_ready                (ip_payload_ready),
        .ip_payload                      (ip_payload),
        .udp_hdr_valid                   (udp_hdr_valid),
        .udp_hdr_ready                   (udp_hdr_ready),
        .udp_hdr                         (udp_hdr),
        .int_beat                        (int_beat),
        .int_valid                       (int_valid),
        .int_ready_early                 (int_ready_early),
        .busy                            (busy),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination)
    );

    axis_skid_buffer skid0 (
        .clk            (clk),
        .rst            (rst),
        .in_beat        (int_beat),
        .in_valid       (int_valid),
        .in_ready_early (int_ready_early),
        .out_beat       (udp_payload),
        .out_valid      (udp_payload_valid),
        .out_ready      (udp_payload_ready)
    );

endmodule

// File: udp_rx_ctrl.sv
// UDP receive controller
// header capture, length trimming and error flags

`timescale 1ns/1ps

module udp_rx_ctrl
    import net_hdr_pkg::*, axis_beat_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       ip_hdr_valid,
    output logic       ip_hdr_ready,
    input  ip_hdr_t    ip_hdr,

    input  logic       ip_payload_valid,
    output logic       ip_payload_ready,
    input  axis_beat_t ip_payload,

    output logic       udp_hdr_valid,
    input  logic       udp_hdr_ready,
    output udp_hdr_t   udp_hdr,

    output axis_beat_t int_beat,
    output logic       int_valid,
    input  logic       int_ready_early,

    output logic       busy,
    output logic       error_header_early_termination,
    output logic       error_payload_early_termination
);

    typedef enum logic [1:0] {
        IDLE,
        READ_HEADER,
        READ_PAYLOAD,
        READ_PAYLOAD_LAST
    } rx_state_t;

    rx_state_t state_reg;
    rx_state_t state_next;

    logic   hdr_ready_next;
    logic   payload_ready_next;
    logic   udp_hdr_valid_next;
    logic   err_hdr_next;
    logic   err_payload_next;

    logic   store_ip_hdr;
    logic   store_udp_word;
    logic   store_last_word;
    logic   payload_fire;

    len16_t frame_ptr_reg;
    len16_t frame_ptr_next;
    len16_t ptr_sum;
    len16_t remain;

    // trimmed word waiting for the input tlast
    data_t  last_data_reg;
    keep_t  last_keep_reg;

    assign payload_fire = ip_payload_valid && ip_payload_ready;
    assign ptr_sum      = frame_ptr_reg + len16_t'(keep_to_count(ip_payload.keep));
    assign remain       = udp_hdr.length - frame_ptr_reg;

    always_comb begin
        state_next         = state_reg;
        hdr_ready_next     = 1'b0;
        payload_ready_next = 1'b0;
        udp_hdr_valid_next = udp_hdr_valid && !udp_hdr_ready;
        err_hdr_next       = 1'b0;
        err_payload_next   = 1'b0;
        store_ip_hdr       = 1'b0;
        store_udp_word     = 1'b0;
        store_last_word    = 1'b0;
        frame_ptr_next     = frame_ptr_reg;
        int_beat           = '0;
        int_valid          = 1'b0;

        case (state_reg)
            IDLE: begin
                frame_ptr_next = '0;
                // no new frame while the previous header is still pending
                hdr_ready_next = !udp_hdr_valid_next;
                if (ip_hdr_ready && ip_hdr_valid) begin
                    hdr_ready_next     = 1'b0;
                    payload_ready_next = 1'b1;
                    store_ip_hdr       = 1'b1;
                    state_next         = READ_HEADER;
                end
            end
            READ_HEADER: begin
                payload_ready_next = 1'b1;
                if (payload_fire) begin
                    if (ip_payload.last) begin
                        // frame ended inside the udp header
                        err_hdr_next       = 1'b1;
                        hdr_ready_next     = !udp_hdr_valid_next;
                        payload_ready_next = 1'b0;
                        state_next         = IDLE;
                    end else begin
                        store_udp_word     = 1'b1;
                        udp_hdr_valid_next = 1'b1;
                        frame_ptr_next     = len16_t'(UDP_HDR_BYTES);
                        payload_ready_next = int_ready_early;
                        state_next         = READ_PAYLOAD;
                    end
                end
            end
            READ_PAYLOAD: begin
                payload_ready_next = int_ready_early;
                int_beat           = ip_payload;
                int_valid          = payload_fire;
                if (payload_fire) begin
                    frame_ptr_next = ptr_sum;
                    if (ptr_sum >= udp_hdr.length) begin
                        // udp length reached, drop bytes past it
                        frame_ptr_next = udp_hdr.length;
                        int_beat.keep  = ip_payload.keep & count_to_keep(byte_cnt_t'(remain));
                        if (ip_payload.last) begin
                            hdr_ready_next     = !udp_hdr_valid_next;
                            payload_ready_next = 1'b0;
                            state_next         = IDLE;
                        end else begin
                            store_last_word = 1'b1;
                            int_valid       = 1'b0;
                            state_next      = READ_PAYLOAD_LAST;
                        end
                    end else if (ip_payload.last) begin
                        // short frame, mark the beat bad
                        err_payload_next   = 1'b1;
                        int_beat.user      = 1'b1;
                        hdr_ready_next     = !udp_hdr_valid_next;
                        payload_ready_next = 1'b0;
                        state_next         = IDLE;
                    end
                end
            end
            READ_PAYLOAD_LAST: begin
                // discard padding, release held word on tlast
                payload_ready_next = int_ready_early;
                int_beat.data      = last_data_reg;
                int_beat.keep      = last_keep_reg;
                int_beat.last      = ip_payload.last;
                int_beat.user      = ip_payload.user;
                int_valid          = payload_fire && ip_payload.last;
                if (payload_fire && ip_payload.last) begin
                    hdr_ready_next     = !udp_hdr_valid_next;
                    payload_ready_next = 1'b0;
                    state_next         = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg                       <= IDLE;
            frame_ptr_reg                   <= '0;
            ip_hdr_ready                    <= 1'b0;
            ip_payload_ready                <= 1'b0;
            udp_hdr_valid                   <= 1'b0;
            busy                            <= 1'b0;
            error_header_early_termination  <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state_reg                       <= state_next;
            frame_ptr_reg                   <= frame_ptr_next;
            ip_hdr_ready                    <= hdr_ready_next;
            ip_payload_ready                <= payload_ready_next;
            udp_hdr_valid                   <= udp_hdr_valid_next;
            busy                            <= state_next != IDLE;
            error_header_early_termination  <= err_hdr_next;
            error_payload_early_termination <= err_payload_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_ip_hdr) begin
            udp_hdr.ip <= ip_hdr;
        end
        // udp fields arrive in network order
        if (store_udp_word) begin
            udp_hdr.source_port <= {ip_payload.data[7:0], ip_payload.data[15:8]};
            udp_hdr.dest_port   <= {ip_payload.data[23:16], ip_payload.data[31:24]};
            udp_hdr.length      <= {ip_payload.data[39:32], ip_payload.data[47:40]};
            udp_hdr.checksum    <= {ip_payload.data[55:48], ip_payload.data[63:56]};
        end
        if (store_last_word) begin
            last_data_reg <= int_beat.data;
            last_keep_reg <= int_beat.keep;
        end
    end

    // header and payload phases never overlap
    assert property (@(posedge clk) disable iff (rst) !(ip_hdr_ready && ip_payload_ready))
        else $error("header and payload ready high together");

endmodule
